// ==== cam_stream_macros.svh ====
`ifndef CAM_STREAM_MACROS_SVH
`define CAM_STREAM_MACROS_SVH

// ==============================
// Data path widths
// ==============================
`define CS_PIX_W          16    // Camera pixel word
`define CS_BYTE_W         8     // USB byte stream
`define CS_LVL_W          12    // Byte level, 0 to 2048

// ==============================
// Stream FIFO sizing
// ==============================
`define CS_FIFO_BYTES     2048  // Depth in bytes
`define CS_AFULL_MARGIN   4     // Free bytes left when almost-full rises

// ==============================
// Config registers
// ==============================
`define CS_CFG_ADDR_W     2     // Register address width
`define CS_CFG_DATA_W     16    // Register write data width
`define CS_REG_MARKER_LEN 0     // Marker length register
`define CS_REG_PKT_THRESH 1     // Packet threshold register
`define CS_MARKER_LEN_RST 1000  // Marker is len plus one zero words
`define CS_PKT_THRESH_RST 512   // One high speed bulk packet

`endif

// ==== cam_stream_pkg.sv ====
`default_nettype none

`include "cam_stream_macros.svh"

package cam_stream_pkg;

  // ==============================
  // Vector types
  // ==============================
  typedef logic [`CS_PIX_W-1:0]      pixel_t;        // Camera or reordered word
  typedef logic [`CS_BYTE_W-1:0]     stream_byte_t;  // One USB byte
  typedef logic [`CS_LVL_W-1:0]      fifo_level_t;   // Byte count, level and threshold
  typedef logic [`CS_CFG_DATA_W-1:0] marker_len_t;   // Marker length, words minus one
  typedef logic [`CS_CFG_ADDR_W-1:0] cfg_addr_t;     // Register address
  typedef logic [`CS_CFG_DATA_W-1:0] cfg_data_t;     // Register write value

  // ==============================
  // Frame marker FSM
  // ==============================
  typedef enum logic {
    MK_IDLE,    // Passing camera words
    MK_ACTIVE   // Emitting zero words
  } marker_state_t;

endpackage

`default_nettype wire

// ==== stream_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cam_stream_macros.svh"

module stream_cfg_regs (
  input  logic                        cmos_pclk,     // Pixel clock
  input  logic                        I_rst_n,       // Async reset, active low
  input  logic                        cfg_we_i,      // Write strobe
  input  cam_stream_pkg::cfg_addr_t   cfg_addr_i,    // Register select
  input  cam_stream_pkg::cfg_data_t   cfg_wdata_i,   // Write value
  output cam_stream_pkg::marker_len_t marker_len_o,  // Zero words per marker, minus one
  output cam_stream_pkg::fifo_level_t pkt_thresh_o   // Bytes needed before reads
);

  // Register addresses in the local address type
  localparam cam_stream_pkg::cfg_addr_t addr_marker_len =
    cam_stream_pkg::cfg_addr_t'(`CS_REG_MARKER_LEN);
  localparam cam_stream_pkg::cfg_addr_t addr_pkt_thresh =
    cam_stream_pkg::cfg_addr_t'(`CS_REG_PKT_THRESH);

  cam_stream_pkg::marker_len_t marker_len_q;  // Marker length register
  cam_stream_pkg::fifo_level_t pkt_thresh_q;  // Packet threshold register
  logic                        we_marker;     // Write hits marker length
  logic                        we_thresh;     // Write hits threshold

  // Address decode
  assign we_marker = cfg_we_i & (cfg_addr_i == addr_marker_len);
  assign we_thresh = cfg_we_i & (cfg_addr_i == addr_pkt_thresh);

  // ==============================
  // Register storage
  // ==============================
  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      marker_len_q <= cam_stream_pkg::marker_len_t'(`CS_MARKER_LEN_RST);  // 1001 words
      pkt_thresh_q <= cam_stream_pkg::fifo_level_t'(`CS_PKT_THRESH_RST);  // 512 bytes
    end else begin
      if (we_marker) begin
        marker_len_q <= cfg_wdata_i;  // Full 16 bits
      end
      if (we_thresh) begin
        pkt_thresh_q <= cfg_wdata_i[`CS_LVL_W-1:0];  // Low 12 bits only
      end
      // Other addresses fall through untouched
    end
  end

  assign marker_len_o = marker_len_q;  // Level to inserter
  assign pkt_thresh_o = pkt_thresh_q;  // Level to FIFO read gate

endmodule

`default_nettype wire

// ==== frame_marker_inserter.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_marker_inserter (
  input  logic                        cmos_pclk,     // Pixel clock
  input  logic                        I_rst_n,       // Async reset, active low
  input  logic                        cam_vsync_i,   // Frame sync level
  input  logic                        cam_de_i,      // Camera word strobe
  input  cam_stream_pkg::pixel_t      cam_data_i,    // Packed RGB565 word
  input  cam_stream_pkg::marker_len_t marker_len_i,  // Marker words minus one
  input  logic                        afull_i,       // FIFO almost full
  output logic                        wr_en_o,       // FIFO write strobe
  output cam_stream_pkg::pixel_t      wr_data_o      // FIFO write word
);

  cam_stream_pkg::marker_state_t state_q;       // Marker FSM
  cam_stream_pkg::marker_len_t   mk_cnt_q;      // Zero words emitted so far
  logic                          vsync_q;       // Vsync one cycle back
  logic                          vsync_rise;    // Low to high on vsync
  logic                          mk_active;     // FSM in marker
  logic                          mk_start;      // Edge that opens a marker
  logic                          mk_emit;       // Zero word goes out
  logic                          mk_last;       // Final zero word
  logic                          pix_accept;    // Camera word goes out
  cam_stream_pkg::pixel_t        pix_rgb;       // Reordered camera word
  logic                          wr_en_q;       // Registered strobe
  cam_stream_pkg::pixel_t        wr_data_q;     // Registered word

  // ==============================
  // Sampling and decisions
  // ==============================
  assign vsync_rise = cam_vsync_i & ~vsync_q;                 // High now, low before
  assign mk_active  = (state_q == cam_stream_pkg::MK_ACTIVE);
  assign mk_start   = vsync_rise & ~mk_active & ~afull_i;     // Otherwise edge is lost
  assign mk_emit    = mk_active & ~afull_i;                   // Pause while almost full
  assign mk_last    = (mk_cnt_q >= marker_len_i);             // Counter ran 0 to len
  assign pix_accept = ~mk_active & cam_de_i & ~afull_i;       // Dropped in marker or afull

  // Camera packs blue high, so swap to red, green, blue
  assign pix_rgb = {cam_data_i[4:0], cam_data_i[10:5], cam_data_i[15:11]};

  // ==============================
  // Marker FSM and word counter
  // ==============================
  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      state_q  <= cam_stream_pkg::MK_IDLE;
      mk_cnt_q <= '0;
      vsync_q  <= 1'b0;
    end else begin
      vsync_q <= cam_vsync_i;  // Edge detect history
      case (state_q)
        cam_stream_pkg::MK_IDLE: begin
          if (mk_start) begin
            state_q  <= cam_stream_pkg::MK_ACTIVE;
            mk_cnt_q <= '0;  // First zero word next cycle
          end
        end
        cam_stream_pkg::MK_ACTIVE: begin
          if (mk_emit) begin
            if (mk_last) begin
              state_q <= cam_stream_pkg::MK_IDLE;  // len plus one words done
            end else begin
              mk_cnt_q <= mk_cnt_q + 1'b1;
            end
          end
        end
        default: begin
          state_q <= cam_stream_pkg::MK_IDLE;
        end
      endcase
    end
  end

  // ==============================
  // Registered FIFO write port
  // ==============================
  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= pix_accept | mk_emit;  // One cycle after sampling
    end
  end

  // Payload, zero during marker
  always_ff @(posedge cmos_pclk) begin
    wr_data_q <= mk_active ? '0 : pix_rgb;
  end

  assign wr_en_o   = wr_en_q;
  assign wr_data_o = wr_data_q;

endmodule

`default_nettype wire

// ==== stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cam_stream_macros.svh"

module stream_fifo (
  input  logic                         cmos_pclk,     // Pixel clock
  input  logic                         I_rst_n,       // Async reset, active low
  input  logic                         wr_en_i,       // Word write strobe
  input  cam_stream_pkg::pixel_t       wr_data_i,     // Word, low byte read first
  input  cam_stream_pkg::fifo_level_t  pkt_thresh_i,  // Bytes needed before a pop
  input  logic                         rd_pop_i,      // USB byte request
  output logic                         afull_o,       // Almost full level
  output cam_stream_pkg::stream_byte_t rd_data_o,     // Popped byte
  output logic                         rd_valid_o     // Byte valid, one cycle after pop
);

  // ==============================
  // Sizing
  // ==============================
  localparam int unsigned word_depth = `CS_FIFO_BYTES / 2;          // Two bytes per entry
  localparam int unsigned wr_aw      = $clog2(word_depth);          // Word pointer
  localparam int unsigned rd_aw      = $clog2(`CS_FIFO_BYTES);      // Byte pointer
  localparam cam_stream_pkg::fifo_level_t afull_lvl =
    cam_stream_pkg::fifo_level_t'(`CS_FIFO_BYTES - `CS_AFULL_MARGIN);
  localparam cam_stream_pkg::fifo_level_t lvl_one = cam_stream_pkg::fifo_level_t'(1);
  localparam cam_stream_pkg::fifo_level_t lvl_two = cam_stream_pkg::fifo_level_t'(2);

  cam_stream_pkg::pixel_t       mem [word_depth];  // Storage, one word per entry
  logic [wr_aw-1:0]             wr_ptr_q;          // Next word slot
  logic [rd_aw-1:0]             rd_ptr_q;          // Next byte to read
  cam_stream_pkg::fifo_level_t  level_q;           // Bytes stored
  logic                         rd_accept;         // Pop that takes a byte
  cam_stream_pkg::pixel_t       rd_word;           // Entry under read pointer
  cam_stream_pkg::stream_byte_t rd_byte;           // Selected half
  cam_stream_pkg::stream_byte_t rd_data_q;         // Output byte register
  logic                         rd_valid_q;        // Output valid register

  // ==============================
  // Write side
  // ==============================
  always_ff @(posedge cmos_pclk) begin
    if (wr_en_i) begin
      mem[wr_ptr_q] <= wr_data_i;  // Both bytes land together
    end
  end

  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      wr_ptr_q <= '0;
    end else if (wr_en_i) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
    end
  end

  // ==============================
  // Read side
  // ==============================
  // Threshold gate, empty check covers a zero threshold
  assign rd_accept = rd_pop_i & (level_q >= pkt_thresh_i) & (level_q != '0);

  assign rd_word = mem[rd_ptr_q[rd_aw-1:1]];  // Upper bits pick the entry
  assign rd_byte = rd_ptr_q[0] ? rd_word[`CS_PIX_W-1:`CS_BYTE_W]
                               : rd_word[`CS_BYTE_W-1:0];  // Low byte first

  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      rd_ptr_q   <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_accept;  // Rejected pop gives no byte
      if (rd_accept) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge cmos_pclk) begin
    if (rd_accept) begin
      rd_data_q <= rd_byte;  // Held until next pop
    end
  end

  // ==============================
  // Byte level
  // ==============================
  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      level_q <= '0;
    end else begin
      case ({wr_en_i, rd_accept})
        2'b10:   level_q <= level_q + lvl_two;  // Word in
        2'b01:   level_q <= level_q - lvl_one;  // Byte out
        2'b11:   level_q <= level_q + lvl_one;  // Both, net one
        default: level_q <= level_q;
      endcase
    end
  end

  // Margin leaves room for words already in flight
  assign afull_o    = (level_q >= afull_lvl);
  assign rd_data_o  = rd_data_q;
  assign rd_valid_o = rd_valid_q;

endmodule

`default_nettype wire

// ==== cam_usb_stream_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_usb_stream_top (
  input  logic                         cmos_pclk,     // Pixel clock, only clock
  input  logic                         I_rst_n,       // Async reset, active low
  input  logic                         cam_vsync_i,   // Frame sync level
  input  logic                         cam_de_i,      // Camera word strobe
  input  cam_stream_pkg::pixel_t       cam_data_i,    // Packed RGB565 word
  input  logic                         cfg_we_i,      // Register write strobe
  input  cam_stream_pkg::cfg_addr_t    cfg_addr_i,    // Register address
  input  cam_stream_pkg::cfg_data_t    cfg_wdata_i,   // Register value
  input  logic                         tx_pop_i,      // USB byte request
  output cam_stream_pkg::stream_byte_t tx_data_o,     // USB byte
  output logic                         tx_valid_o,    // Byte valid
  output logic                         fifo_afull_o   // Almost full status
);

  // ==============================
  // Internal nets
  // ==============================
  cam_stream_pkg::marker_len_t marker_len;  // Regs to inserter
  cam_stream_pkg::fifo_level_t pkt_thresh;  // Regs to FIFO
  logic                        wr_en;       // Inserter write strobe
  cam_stream_pkg::pixel_t      wr_data;     // Inserter write word

  // Config registers
  stream_cfg_regs u_cfg_regs (
    .cmos_pclk    (cmos_pclk),
    .I_rst_n      (I_rst_n),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .marker_len_o (marker_len),
    .pkt_thresh_o (pkt_thresh)
  );

  // Reorder and marker insertion
  frame_marker_inserter u_inserter (
    .cmos_pclk    (cmos_pclk),
    .I_rst_n      (I_rst_n),
    .cam_vsync_i  (cam_vsync_i),
    .cam_de_i     (cam_de_i),
    .cam_data_i   (cam_data_i),
    .marker_len_i (marker_len),
    .afull_i      (fifo_afull_o),  // Back-pressure by dropping
    .wr_en_o      (wr_en),
    .wr_data_o    (wr_data)
  );

  // Byte FIFO toward USB
  stream_fifo u_fifo (
    .cmos_pclk    (cmos_pclk),
    .I_rst_n      (I_rst_n),
    .wr_en_i      (wr_en),
    .wr_data_i    (wr_data),
    .pkt_thresh_i (pkt_thresh),
    .rd_pop_i     (tx_pop_i),
    .afull_o      (fifo_afull_o),  // Also seen outside
    .rd_data_o    (tx_data_o),
    .rd_valid_o   (tx_valid_o)
  );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,    // 8 ns pixel clock
  output logic rst_n_o   // Active low reset
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // Half period
  end

  // Held low for 5 rising edges, released away from the edge
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_cam_usb_stream.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cam_stream_macros.svh"

module tb_cam_usb_stream;

  localparam int wait_limit = 20000;  // Cycles per wait loop
  localparam int afull_lvl  = `CS_FIFO_BYTES - `CS_AFULL_MARGIN;

  logic                         cmos_pclk;
  logic                         I_rst_n;
  logic                         cam_vsync_i;
  logic                         cam_de_i;
  cam_stream_pkg::pixel_t       cam_data_i;
  logic                         cfg_we_i;
  cam_stream_pkg::cfg_addr_t    cfg_addr_i;
  cam_stream_pkg::cfg_data_t    cfg_wdata_i;
  logic                         tx_pop_i;
  cam_stream_pkg::stream_byte_t tx_data_o;
  logic                         tx_valid_o;
  logic                         fifo_afull_o;

  // Stimulus for the next cycle
  logic                         s_vsync;
  logic                         s_de;
  logic                         s_pop;
  logic                         s_we;
  cam_stream_pkg::pixel_t       s_data;
  cam_stream_pkg::cfg_addr_t    s_addr;
  cam_stream_pkg::cfg_data_t    s_wdata;

  // ==============================
  // Reference model state
  // ==============================
  cam_stream_pkg::stream_byte_t m_q[$];       // Bytes stored
  logic                         m_pend_valid; // Word in flight to FIFO
  cam_stream_pkg::pixel_t       m_pend_word;
  logic                         m_active;     // Marker running
  int                           m_left;       // Zero words still owed
  logic                         m_vs_prev;
  cam_stream_pkg::marker_len_t  m_len;
  cam_stream_pkg::fifo_level_t  m_thresh;
  logic                         m_exp_valid;  // Byte due on output
  cam_stream_pkg::stream_byte_t m_exp_byte;
  int                           m_out_count;  // Bytes seen on tx_data_o
  integer                       seed;
  int                           i;
  int                           n;
  int                           out_before;

  tb_clk_gen u_clk_gen (.clk_o(cmos_pclk), .rst_n_o(I_rst_n));

  cam_usb_stream_top UUT (
    .cmos_pclk    (cmos_pclk),
    .I_rst_n      (I_rst_n),
    .cam_vsync_i  (cam_vsync_i),
    .cam_de_i     (cam_de_i),
    .cam_data_i   (cam_data_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .tx_pop_i     (tx_pop_i),
    .tx_data_o    (tx_data_o),
    .tx_valid_o   (tx_valid_o),
    .fifo_afull_o (fifo_afull_o)
  );

  // ==============================
  // Failure reporting
  // ==============================
  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic value_error(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic timeout_error(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    stop_run();
  endtask

  task automatic check_byte(input cam_stream_pkg::stream_byte_t got,
                            input cam_stream_pkg::stream_byte_t exp);
    if (got !== exp) begin
      value_error($sformatf("tx_data_o is %02h, expected %02h", got, exp));
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      value_error($sformatf("tx_valid_o is %b, expected %b", got, exp));
    end
  endtask

  task automatic check_afull(input logic got, input logic exp);
    if (got !== exp) begin
      value_error($sformatf("fifo_afull_o is %b, expected %b", got, exp));
    end
  endtask

  // Camera order has blue in 15:11 and red in 4:0
  function automatic cam_stream_pkg::pixel_t to_rgb(input cam_stream_pkg::pixel_t d);
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
    red   = d[4:0];
    green = d[10:5];
    blue  = d[15:11];
    return {red, green, blue};
  endfunction

  // Model of one rising edge with the inputs as driven
  task automatic model_step();
    logic afull;
    afull = (m_q.size() >= afull_lvl);  // Level before the edge
    m_exp_valid = s_pop && (m_q.size() >= m_thresh) && (m_q.size() != 0);
    if (m_exp_valid) begin
      m_exp_byte = m_q.pop_front();
    end
    if (m_pend_valid) begin
      m_q.push_back(m_pend_word[7:0]);   // Low byte first
      m_q.push_back(m_pend_word[15:8]);
    end
    m_pend_valid = 1'b0;
    if (m_active) begin
      if (!afull) begin
        m_pend_valid = 1'b1;
        m_pend_word  = '0;
        m_left--;
        m_active = (m_left != 0);
      end
    end else begin
      if (s_vsync && !m_vs_prev && !afull) begin
        m_active = 1'b1;
        m_left   = int'(m_len) + 1;
      end
      if (s_de && !afull) begin
        m_pend_valid = 1'b1;  // Start cycle still takes the word
        m_pend_word  = to_rgb(s_data);
      end
    end
    m_vs_prev = s_vsync;
    if (s_we && s_addr == `CS_REG_MARKER_LEN) begin
      m_len = s_wdata;
    end
    if (s_we && s_addr == `CS_REG_PKT_THRESH) begin
      m_thresh = s_wdata[`CS_LVL_W-1:0];
    end
  endtask

  // Check the last edge and drive the next inputs
  task automatic tick();
    @(negedge cmos_pclk);
    check_valid(tx_valid_o, m_exp_valid);
    if (m_exp_valid) begin
      check_byte(tx_data_o, m_exp_byte);
    end
    if (tx_valid_o === 1'b1) begin
      m_out_count++;
    end
    check_afull(fifo_afull_o, m_q.size() >= afull_lvl);
    cam_vsync_i = s_vsync;
    cam_de_i    = s_de;
    cam_data_i  = s_data;
    tx_pop_i    = s_pop;
    cfg_we_i    = s_we;
    cfg_addr_i  = s_addr;
    cfg_wdata_i = s_wdata;
    model_step();
  endtask

  task automatic write_reg(input int addr, input int value);
    s_we    = 1'b1;
    s_addr  = cam_stream_pkg::cfg_addr_t'(addr);
    s_wdata = cam_stream_pkg::cfg_data_t'(value);
    tick();
    s_we = 1'b0;
  endtask

  // Pop until the model holds less than a threshold
  task automatic drain(input string what);
    int k;
    k = 0;
    s_de  = 1'b0;
    s_pop = 1'b1;
    while (m_active || m_pend_valid || (m_q.size() >= m_thresh)) begin
      if (k >= wait_limit) begin
        timeout_error(what);
      end
      tick();
      k++;
    end
    s_pop = 1'b0;
    tick();  // Last byte checked here
  endtask

  // Vsync pulse and random camera words until the marker ends
  task automatic run_marker(input string what);
    int k;
    k = 0;
    s_vsync = 1'b1;
    tick();
    s_vsync = 1'b0;
    s_pop   = 1'b1;
    while (m_active) begin
      if (k >= wait_limit) begin
        timeout_error(what);
      end
      s_de   = ($random(seed) & 1) != 0;   // Dropped while marker runs
      s_data = cam_stream_pkg::pixel_t'($random(seed));
      tick();
      k++;
    end
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    seed = 32'h3aae_2899;
    {cam_vsync_i, cam_de_i, tx_pop_i, cfg_we_i} = '0;
    cam_data_i  = '0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    {s_vsync, s_de, s_pop, s_we} = '0;
    s_data  = '0;
    s_addr  = '0;
    s_wdata = '0;
    m_q.delete();
    {m_pend_valid, m_active, m_vs_prev, m_exp_valid} = '0;
    m_pend_word = '0;
    m_left      = 0;
    m_exp_byte  = '0;
    m_out_count = 0;
    m_len    = cam_stream_pkg::marker_len_t'(`CS_MARKER_LEN_RST);
    m_thresh = cam_stream_pkg::fifo_level_t'(`CS_PKT_THRESH_RST);

    n = 0;
    while (!I_rst_n) begin
      if (n >= 100) begin
        timeout_error("reset release");
      end
      @(posedge cmos_pclk);
      n++;
    end

    // Idle outputs and pops on an empty FIFO
    s_pop = 1'b1;
    repeat (10) tick();

    // Random pixels below almost full
    for (i = 0; i < 600; i++) begin
      s_de   = ($random(seed) & 3) != 0;
      s_data = cam_stream_pkg::pixel_t'($random(seed));
      s_pop  = ($random(seed) & 1) != 0;
      tick();
    end
    drain("drain after pixel stream");

    // Default marker of 1001 zero words
    run_marker("default marker");
    drain("drain after default marker");

    // Short marker and low threshold with a write to unused address 2
    write_reg(`CS_REG_MARKER_LEN, 7);
    write_reg(`CS_REG_PKT_THRESH, 16);
    write_reg(2, 16'h5a5a);
    drain("drain to new threshold");
    run_marker("short marker");
    drain("drain after short marker");

    // Fill without pops until almost full and keep sending
    s_pop = 1'b0;
    s_de  = 1'b1;
    n = 0;
    while (!fifo_afull_o) begin
      if (n >= wait_limit) begin
        timeout_error("almost full");
      end
      s_data = cam_stream_pkg::pixel_t'($random(seed));
      tick();
      n++;
    end
    for (i = 0; i < 50; i++) begin
      s_data = cam_stream_pkg::pixel_t'($random(seed));
      tick();
    end
    out_before = m_out_count;
    drain("drain of full FIFO");
    if (m_out_count - out_before > `CS_FIFO_BYTES) begin
      value_error($sformatf("drained %0d bytes, more than FIFO depth",
                            m_out_count - out_before));
    end
    repeat (5) tick();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
cam_stream_pkg.sv
stream_cfg_regs.sv
frame_marker_inserter.sv
stream_fifo.sv
cam_usb_stream_top.sv
tb_clk_gen.sv
tb_cam_usb_stream.sv

// ==== Bender.yml ====
package:
  name: cam_usb_stream

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cam_stream_pkg.sv
      - stream_cfg_regs.sv
      - frame_marker_inserter.sv
      - stream_fifo.sv
      - cam_usb_stream_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_cam_usb_stream.sv
